/* rtl/cdi_defs.svh */
`ifndef CDI_DEFS_SVH
`define CDI_DEFS_SVH

// ========================================
// Data and address widths
// ========================================

`define CDI_WORD_W 16
`define CDI_SDRAM_ADDR_W 25
`define CDI_NVRAM_ADDR_W 13

// Prefix above the download word address, selects the boot ROM area in SDRAM
`define CDI_ROM_REGION 3'b001

// Early-boot window in which NvRAM changes are not worth a backup
// Short value for simulation
`define CDI_NVRAM_IGNORE_CYCLES 4

`endif

/* rtl/cdi_mem_pkg.sv */
`include "cdi_defs.svh"

package cdi_mem_pkg;

    // One beat of the host download channel
    typedef struct packed {
        logic                         wr;
        logic [`CDI_SDRAM_ADDR_W-1:0] addr;
        logic [`CDI_WORD_W-1:0]       data;
        // Index bit, set for the slave WORM image
        logic                         slave_sel;
        logic                         active;
    } dl_req_t;

    // Request towards the SDRAM controller
    typedef struct packed {
        logic [`CDI_SDRAM_ADDR_W-1:0] addr;
        logic [`CDI_WORD_W-1:0]       din;
        logic                         rd;
        logic                         wr;
        logic                         word;
        logic                         refresh;
        logic                         burst;
    } sdram_req_t;

    // Byte write into the slave WORM
    typedef struct packed {
        logic [`CDI_NVRAM_ADDR_W-1:0] adr;
        logic [7:0]                   data;
        logic                         wr;
    } worm_wr_t;

    // Download beats come first, refresh fills the gaps
    typedef enum logic [1:0] {
        ROM_DOWNLOAD,
        REFRESH,
        IDLE
    } sdram_owner_t;

endpackage

/* rtl/cdi_nvram_pkg.sv */
`include "cdi_defs.svh"

package cdi_nvram_pkg;

    // Host side into the design
    typedef struct packed {
        logic                   ack;
        logic                   buff_wr;
        logic                   buff_addr_lsb;
        logic [`CDI_WORD_W-1:0] buff_dout;
        logic                   media_change;
        logic                   img_nonzero;
    } hps_nv_in_t;

    // Host side out of the design
    typedef struct packed {
        logic                   rd;
        logic                   wr;
        logic [`CDI_WORD_W-1:0] din;
    } hps_nv_out_t;

    // Towards the NvRAM inside the core
    typedef struct packed {
        logic [`CDI_NVRAM_ADDR_W-1:0] adr;
        logic [7:0]                   restore_data;
        logic                         restore_write;
        logic                         allow_cpu_access;
    } nv_core_t;

    // Commands from the sequencer to the byte path
    typedef struct packed {
        logic adr_clear;
        logic adr_step;
        logic cap_lo;
        logic cap_hi;
        logic restore_load;
    } nv_cmd_t;

    typedef enum logic [3:0] {
        NV_IDLE,
        NV_WAIT_ACK,
        NV_BACKUP0,
        NV_BACKUP1,
        NV_BACKUP2,
        NV_BACKUP3,
        NV_RESTORE0,
        NV_RESTORE1,
        NV_RESTORE2
    } nvram_state_t;

endpackage

/* rtl/cdi_platform_top.sv */
`timescale 1ns/1ps
`include "cdi_defs.svh"

module cdi_platform_top
    import cdi_mem_pkg::*, cdi_nvram_pkg::*;
(
    input  logic        clk_sys,
    input  logic        cditop_reset,
    input  dl_req_t     dl,
    input  sdram_req_t  core_req,
    input  logic        sdram_busy,
    input  hps_nv_in_t  hps_in,
    input  logic [7:0]  nv_backup_data,
    input  logic        nv_cpu_changed,
    input  logic        osd_status,
    input  logic        reset_on_mount_en,
    output sdram_req_t  sdram_req,
    output worm_wr_t    worm,
    output hps_nv_out_t hps_out,
    output nv_core_t    nv_core,
    output logic        core_hold,
    output logic        backup_pending,
    output logic        dl_overflow
);
    sdram_owner_t                 sdram_owner;
    nv_cmd_t                      nv_cmd;
    logic                         rom_pending;
    logic                         hps_rd;
    logic                         hps_wr;
    logic [`CDI_WORD_W-1:0]       hps_din;
    logic [`CDI_NVRAM_ADDR_W-1:0] nv_adr;
    logic [7:0]                   restore_data;
    logic                         restore_write;
    logic                         allow_cpu_access;

    assign hps_out = '{rd: hps_rd, wr: hps_wr, din: hps_din};
    assign nv_core = '{
        adr:              nv_adr,
        restore_data:     restore_data,
        restore_write:    restore_write,
        allow_cpu_access: allow_cpu_access
    };

    platform_ctrl #(
        .IGNORE_CYCLES(`CDI_NVRAM_IGNORE_CYCLES)
    ) u_ctrl (
        .clk_sys          (clk_sys),
        .cditop_reset     (cditop_reset),
        .dl_active        (dl.active),
        .hps_in           (hps_in),
        .nv_cpu_changed   (nv_cpu_changed),
        .osd_status       (osd_status),
        .reset_on_mount_en(reset_on_mount_en),
        .rom_pending      (rom_pending),
        .sdram_busy       (sdram_busy),
        .core_hold        (core_hold),
        .sdram_owner      (sdram_owner),
        .nv_cmd           (nv_cmd),
        .hps_rd           (hps_rd),
        .hps_wr           (hps_wr),
        .restore_write    (restore_write),
        .allow_cpu_access (allow_cpu_access),
        .backup_pending   (backup_pending)
    );

    sdram_prep_path u_sdram_prep (
        .clk_sys     (clk_sys),
        .cditop_reset(cditop_reset),
        .dl          (dl),
        .core_hold   (core_hold),
        .sdram_owner (sdram_owner),
        .sdram_busy  (sdram_busy),
        .core_req    (core_req),
        .sdram_req   (sdram_req),
        .rom_pending (rom_pending),
        .dl_overflow (dl_overflow)
    );

    worm_loader u_worm (
        .clk_sys     (clk_sys),
        .cditop_reset(cditop_reset),
        .dl          (dl),
        .worm        (worm)
    );

    nvram_byte_path u_nv_bytes (
        .clk_sys       (clk_sys),
        .nv_cmd        (nv_cmd),
        .hps_buff_dout (hps_in.buff_dout),
        .nv_backup_data(nv_backup_data),
        .nv_adr        (nv_adr),
        .hps_din       (hps_din),
        .restore_data  (restore_data)
    );

endmodule

/* rtl/nvram_byte_path.sv */
`timescale 1ns/1ps
`include "cdi_defs.svh"

module nvram_byte_path
    import cdi_nvram_pkg::*;
(
    input  logic                         clk_sys,
    input  nv_cmd_t                      nv_cmd,
    input  logic [`CDI_WORD_W-1:0]       hps_buff_dout,
    input  logic [7:0]                   nv_backup_data,
    output logic [`CDI_NVRAM_ADDR_W-1:0] nv_adr,
    output logic [`CDI_WORD_W-1:0]       hps_din,
    output logic [7:0]                   restore_data
);
    logic [`CDI_WORD_W-1:0] restore_word;

    // Byte address shared by backup and restore
    always_ff @(posedge clk_sys) begin
        if (nv_cmd.adr_clear) begin
            nv_adr <= '0;
        end else if (nv_cmd.adr_step) begin
            nv_adr <= nv_adr + 1'b1;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (nv_cmd.cap_lo) begin
            hps_din[7:0] <= nv_backup_data;
        end
        if (nv_cmd.cap_hi) begin
            hps_din[15:8] <= nv_backup_data;
        end
        if (nv_cmd.restore_load) begin
            restore_word <= hps_buff_dout;
        end
    end

    // Even address takes the low byte
    assign restore_data = nv_adr[0] ? restore_word[15:8] : restore_word[7:0];

endmodule

/* rtl/platform_ctrl.sv */
`timescale 1ns/1ps
`include "cdi_defs.svh"

module platform_ctrl
    import cdi_mem_pkg::*, cdi_nvram_pkg::*;
#(
    parameter int IGNORE_CYCLES = `CDI_NVRAM_IGNORE_CYCLES
) (
    input  logic         clk_sys,
    input  logic         cditop_reset,
    input  logic         dl_active,
    input  hps_nv_in_t   hps_in,
    input  logic         nv_cpu_changed,
    input  logic         osd_status,
    input  logic         reset_on_mount_en,
    input  logic         rom_pending,
    input  logic         sdram_busy,
    output logic         core_hold,
    output sdram_owner_t sdram_owner,
    output nv_cmd_t      nv_cmd,
    output logic         hps_rd,
    output logic         hps_wr,
    output logic         restore_write,
    output logic         allow_cpu_access,
    output logic         backup_pending
);
    localparam int CNT_W = $clog2(IGNORE_CYCLES + 1);

    sdram_owner_t     owner_q;
    sdram_owner_t     owner_next;
    nvram_state_t     state;
    logic [CNT_W-1:0] ignore_cnt;
    logic             mounted;
    logic             osd_q;
    logic             lsb_q;
    logic             img_mount;
    logic             osd_rise;
    logic             lsb_toggle;
    logic             backup_start;

    assign img_mount    = hps_in.media_change && hps_in.img_nonzero;
    assign osd_rise     = osd_status && !osd_q;
    assign lsb_toggle   = hps_in.buff_addr_lsb != lsb_q;
    // A mount takes precedence over a backup request
    assign backup_start = (state == NV_IDLE) && !img_mount && backup_pending && osd_rise;

    // ========================================
    // Core hold and SDRAM owner
    // ========================================

    always_ff @(posedge clk_sys) begin
        core_hold <= cditop_reset || dl_active || (img_mount && reset_on_mount_en);
    end

    always_comb begin
        owner_next = IDLE;
        if (core_hold) begin
            owner_next = rom_pending ? ROM_DOWNLOAD : REFRESH;
        end
        // Keep the owner of an access in flight
        sdram_owner = sdram_busy ? owner_q : owner_next;
    end

    always_ff @(posedge clk_sys) begin
        if (cditop_reset) begin
            owner_q <= IDLE;
        end else begin
            owner_q <= sdram_owner;
        end
    end

    // ========================================
    // Mount flag, edges and backup request
    // ========================================

    always_ff @(posedge clk_sys) begin
        if (cditop_reset) begin
            mounted <= 1'b0;
            osd_q   <= 1'b0;
            lsb_q   <= 1'b0;
        end else begin
            osd_q <= osd_status;
            lsb_q <= hps_in.buff_addr_lsb;
            if (hps_in.media_change) begin
                mounted <= hps_in.img_nonzero;
            end
        end
    end

    // The OS writes NvRAM while booting, those changes are not backed up
    always_ff @(posedge clk_sys) begin
        if (cditop_reset || core_hold) begin
            ignore_cnt     <= CNT_W'(IGNORE_CYCLES);
            backup_pending <= 1'b0;
        end else begin
            if (ignore_cnt != '0) begin
                ignore_cnt <= ignore_cnt - 1'b1;
            end
            if (backup_start) begin
                backup_pending <= 1'b0;
            end else if (ignore_cnt == '0 && nv_cpu_changed && mounted) begin
                backup_pending <= 1'b1;
            end
        end
    end

    // ========================================
    // NvRAM backup and restore FSM
    // ========================================

    always_ff @(posedge clk_sys) begin
        if (cditop_reset) begin
            state            <= NV_IDLE;
            hps_rd           <= 1'b0;
            hps_wr           <= 1'b0;
            restore_write    <= 1'b0;
            allow_cpu_access <= 1'b1;
        end else begin
            restore_write <= 1'b0;
            // Requests are levels until the host acknowledges
            if (hps_in.ack) begin
                hps_rd <= 1'b0;
                hps_wr <= 1'b0;
            end

            case (state)
                NV_IDLE: begin
                    allow_cpu_access <= 1'b1;
                    if (img_mount) begin
                        hps_rd           <= 1'b1;
                        allow_cpu_access <= 1'b0;
                        state            <= NV_WAIT_ACK;
                    end else if (backup_start) begin
                        hps_wr           <= 1'b1;
                        allow_cpu_access <= 1'b0;
                        state            <= NV_WAIT_ACK;
                    end
                end
                NV_WAIT_ACK: begin
                    if (hps_in.ack && hps_rd) begin
                        state <= NV_RESTORE0;
                    end
                    if (hps_in.ack && hps_wr) begin
                        state <= NV_BACKUP0;
                    end
                end
                // Byte path steps the address ahead of the NvRAM read latency
                NV_BACKUP0: state <= NV_BACKUP1;
                NV_BACKUP1: state <= NV_BACKUP2;
                NV_BACKUP2: state <= NV_BACKUP3;
                NV_BACKUP3: begin
                    if (lsb_toggle) begin
                        state <= NV_BACKUP1;
                    end
                    if (!hps_in.ack) begin
                        state <= NV_IDLE;
                    end
                end
                NV_RESTORE0: begin
                    if (hps_in.buff_wr) begin
                        restore_write <= 1'b1;
                        state         <= NV_RESTORE1;
                    end
                    if (!hps_in.ack) begin
                        allow_cpu_access <= 1'b1;
                        state            <= NV_IDLE;
                    end
                end
                NV_RESTORE1: begin
                    restore_write <= 1'b1;
                    state         <= NV_RESTORE2;
                end
                NV_RESTORE2: state <= NV_RESTORE0;
                default:     state <= NV_IDLE;
            endcase
        end
    end

    always_comb begin
        nv_cmd              = '0;
        nv_cmd.adr_clear    = (state == NV_IDLE);
        nv_cmd.cap_lo       = (state == NV_BACKUP1);
        nv_cmd.cap_hi       = (state == NV_BACKUP2);
        nv_cmd.restore_load = (state == NV_RESTORE0) && hps_in.buff_wr;
        case (state)
            NV_BACKUP0, NV_BACKUP1, NV_RESTORE1, NV_RESTORE2: nv_cmd.adr_step = 1'b1;
            NV_BACKUP3: nv_cmd.adr_step = lsb_toggle;
            default:    nv_cmd.adr_step = 1'b0;
        endcase
    end

    // Host channel moves one direction at a time
    a_hps_one_dir: assert property (
        @(posedge clk_sys) disable iff (cditop_reset) !(hps_rd && hps_wr)
    );

endmodule

/* rtl/sdram_prep_path.sv */
`timescale 1ns/1ps
`include "cdi_defs.svh"

module sdram_prep_path
    import cdi_mem_pkg::*;
(
    input  logic         clk_sys,
    input  logic         cditop_reset,
    input  dl_req_t      dl,
    input  logic         core_hold,
    input  sdram_owner_t sdram_owner,
    input  logic         sdram_busy,
    input  sdram_req_t   core_req,
    output sdram_req_t   sdram_req,
    output logic         rom_pending,
    output logic         dl_overflow
);
    sdram_owner_t owner_q;
    sdram_req_t   prep_req;
    logic         busy_q;
    logic         rom_wr;
    logic         rom_done;

    assign rom_wr   = dl.wr && !dl.slave_sel;
    // Download word written once busy drops behind it
    assign rom_done = (owner_q == ROM_DOWNLOAD) && busy_q && !sdram_busy;

    always_ff @(posedge clk_sys) begin
        if (cditop_reset) begin
            owner_q     <= IDLE;
            busy_q      <= 1'b0;
            rom_pending <= 1'b0;
            dl_overflow <= 1'b0;
        end else begin
            owner_q <= sdram_owner;
            busy_q  <= sdram_busy;
            if (rom_pending && dl.wr) begin
                dl_overflow <= 1'b1;
            end
            if (rom_done) begin
                rom_pending <= 1'b0;
            end else if (rom_wr) begin
                rom_pending <= 1'b1;
            end
        end
    end

    always_comb begin
        prep_req      = '0;
        prep_req.word = 1'b1;
        case (sdram_owner)
            ROM_DOWNLOAD: begin
                prep_req.addr = {`CDI_ROM_REGION, dl.addr[21:1], 1'b0};
                // Host words are little endian, the 68k wants big endian
                prep_req.din  = {dl.data[7:0], dl.data[15:8]};
                // No second write on the cycle busy falls
                prep_req.wr   = !busy_q;
            end
            REFRESH: begin
                prep_req.rd      = 1'b1;
                prep_req.refresh = 1'b1;
            end
            default: begin
            end
        endcase

        if (sdram_busy) begin
            prep_req.rd = 1'b0;
            prep_req.wr = 1'b0;
        end
    end

    assign sdram_req = core_hold ? prep_req : core_req;

    // Owner of an access in flight does not change under it
    a_owner_held: assert property (
        @(posedge clk_sys) disable iff (cditop_reset)
        sdram_busy |-> sdram_owner == owner_q
    );

endmodule

/* rtl/worm_loader.sv */
`timescale 1ns/1ps

module worm_loader
    import cdi_mem_pkg::*;
(
    input  logic     clk_sys,
    input  logic     cditop_reset,
    input  dl_req_t  dl,
    output worm_wr_t worm
);
    logic        slave_wr;
    logic        slave_wr_q;
    logic        wr_q;
    logic [12:0] adr_q;
    logic [7:0]  data_q;
    logic [7:0]  high_byte;

    assign slave_wr = dl.wr && dl.slave_sel;

    always_ff @(posedge clk_sys) begin
        if (cditop_reset) begin
            slave_wr_q <= 1'b0;
            wr_q       <= 1'b0;
        end else begin
            slave_wr_q <= slave_wr;
            wr_q       <= slave_wr || slave_wr_q;
        end
    end

    // Low byte first, the high byte waits one cycle
    always_ff @(posedge clk_sys) begin
        if (slave_wr) begin
            adr_q     <= dl.addr[12:0];
            data_q    <= dl.data[7:0];
            high_byte <= dl.data[15:8];
        end else begin
            adr_q[0] <= 1'b1;
            data_q   <= high_byte;
        end
    end

    assign worm = '{adr: adr_q, data: data_q, wr: wr_q};

    a_slave_spacing: assert property (
        @(posedge clk_sys) disable iff (cditop_reset) slave_wr |=> !slave_wr
    );

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the CD-i platform testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f src.f --top-module tb_cdi_platform -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "=== FAIL ===" "$LOG"; then
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi
exit 0

/* src.f */
+incdir+rtl
rtl/cdi_mem_pkg.sv
rtl/cdi_nvram_pkg.sv
rtl/platform_ctrl.sv
rtl/sdram_prep_path.sv
rtl/worm_loader.sv
rtl/nvram_byte_path.sv
rtl/cdi_platform_top.sv
testbench/tb_cdi_platform.sv

/* testbench/tb_cdi_platform.sv */
`timescale 1ns/1ps
`include "cdi_defs.svh"

module tb_cdi_platform
    import cdi_mem_pkg::*, cdi_nvram_pkg::*;
;
    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 4;
    localparam int ROM_WRITES   = 8;
    localparam int ROM_SPACING  = 16;
    localparam int WORM_WRITES  = 2;
    localparam int CORE_CYCLES  = 20;
    localparam int NV_WORDS     = 4;
    // Cycle budget per section, summed
    localparam int TEST_CYCLES  = RESET_CYCLES + 4 + ROM_WRITES * ROM_SPACING
                                + WORM_WRITES * 6 + 3 + CORE_CYCLES
                                + 10 + NV_WORDS * 6 + 3
                                + 25 + 10 + NV_WORDS * 6 + 4;
    localparam int WATCHDOG_NS  = (TEST_CYCLES + 200) * CLK_PERIOD;

    logic        clk_sys = 1'b0;
    logic        cditop_reset;
    dl_req_t     dl;
    sdram_req_t  core_req;
    logic        sdram_busy;
    hps_nv_in_t  hps_in;
    logic [7:0]  nv_backup_data;
    logic        nv_cpu_changed;
    logic        osd_status;
    logic        reset_on_mount_en;
    sdram_req_t  sdram_req;
    worm_wr_t    worm;
    hps_nv_out_t hps_out;
    nv_core_t    nv_core;
    logic        core_hold;
    logic        backup_pending;
    logic        dl_overflow;

    logic [31:0] rand_state = 32'haeeb4a83;
    logic [1:0]  busy_left;
    logic [40:0] rom_expect[$];
    int          rom_writes_seen = 0;
    int          refresh_seen = 0;
    logic [12:0] restore_base;
    logic [15:0] expect_din;
    logic        slave_wr;

    assign slave_wr = dl.wr && dl.slave_sel;

    cdi_platform_top UUT (.*);

    always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

    function automatic logic [7:0] nv_byte(input logic [12:0] adr);
        return adr[7:0] ^ {3'b000, adr[12:8]} ^ 8'h5a;
    endfunction

    function logic [31:0] next_random();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return rand_state;
    endfunction

    task report_mismatch(input string msg);
        $display("CHECK FAILED at %0t ns: %s", $time, msg);
        $display("=== FAIL ===");
        $fatal(1, "Stopped at first error");
    endtask

    task abort_run(input string msg);
        $display("ERROR at %0t ns: %s", $time, msg);
        $display("=== FAIL ===");
        $fatal(1, "Run aborted");
    endtask

    // Host request is a level, wait for it with a bound
    task wait_request(input logic want_wr);
        int n;
        n = 0;
        while (!(want_wr ? hps_out.wr : hps_out.rd)) begin
            @(posedge clk_sys);
            n++;
            if (n > 50) begin
                abort_run("Host request from the NvRAM sequencer never came");
            end
        end
    endtask

    // ========================================
    // Memory models
    // ========================================

    // NvRAM read with one cycle of latency
    always @(posedge clk_sys) begin
        nv_backup_data <= nv_byte(nv_core.adr);
    end

    // SDRAM stays busy for three cycles after each accepted request
    always @(posedge clk_sys) begin
        if (busy_left != 2'd0) begin
            busy_left  <= busy_left - 2'd1;
            sdram_busy <= (busy_left != 2'd1);
        end else if (sdram_req.rd || sdram_req.wr) begin
            busy_left  <= 2'd3;
            sdram_busy <= 1'b1;
        end
    end

    // ROM download scoreboard
    always @(posedge clk_sys) begin
        logic [40:0] expected;
        if (!cditop_reset && dl.wr && !dl.slave_sel) begin
            rom_expect.push_back({`CDI_ROM_REGION, dl.addr[21:1], 1'b0,
                                  dl.data[7:0], dl.data[15:8]});
        end
        if (!cditop_reset && core_hold) begin
            if (sdram_req.rd && sdram_req.refresh) begin
                refresh_seen++;
            end
            if (sdram_req.wr) begin
                assert (rom_expect.size() != 0)
                    else report_mismatch("SDRAM write without a download word");
                assert (refresh_seen > 0)
                    else report_mismatch("No refresh read before this ROM write");
                expected = rom_expect.pop_front();
                assert ({sdram_req.addr, sdram_req.din} == expected)
                    else report_mismatch("ROM write address or data wrong");
                rom_writes_seen++;
                refresh_seen = 0;
            end
        end
    end

    // ========================================
    // Concurrent checks
    // ========================================

    a_hold: assert property (@(posedge clk_sys) disable iff (cditop_reset)
        core_hold == $past(cditop_reset || dl.active
            || (hps_in.media_change && hps_in.img_nonzero && reset_on_mount_en)))
        else report_mismatch("core_hold does not follow its causes");
    a_busy_idle: assert property (@(posedge clk_sys) disable iff (cditop_reset)
        core_hold && sdram_busy |-> !sdram_req.rd && !sdram_req.wr)
        else report_mismatch("SDRAM request while busy");
    a_no_overflow: assert property (@(posedge clk_sys) disable iff (cditop_reset)
        !dl_overflow) else report_mismatch("dl_overflow set with spaced writes");
    a_core_pass: assert property (@(posedge clk_sys) disable iff (cditop_reset)
        !core_hold |-> sdram_req == core_req)
        else report_mismatch("sdram_req differs from core_req");
    a_worm_lo: assert property (@(posedge clk_sys) disable iff (cditop_reset)
        slave_wr |=> worm.wr && worm.adr == $past(dl.addr[12:0])
            && worm.data == $past(dl.data[7:0]))
        else report_mismatch("WORM low byte write wrong");
    a_worm_hi: assert property (@(posedge clk_sys) disable iff (cditop_reset)
        $past(slave_wr, 2) |-> worm.wr && worm.adr == ($past(dl.addr[12:0], 2) | 13'd1)
            && worm.data == $past(dl.data[15:8], 2))
        else report_mismatch("WORM high byte write wrong");
    a_worm_only: assert property (@(posedge clk_sys) disable iff (cditop_reset)
        worm.wr |-> $past(slave_wr) || $past(slave_wr, 2))
        else report_mismatch("Unexpected WORM write");
    a_rest_lo: assert property (@(posedge clk_sys) disable iff (cditop_reset)
        $past(hps_in.buff_wr) |-> nv_core.restore_write && nv_core.adr == $past(restore_base)
            && nv_core.restore_data == $past(hps_in.buff_dout[7:0]))
        else report_mismatch("Restore low byte wrong");
    a_rest_hi: assert property (@(posedge clk_sys) disable iff (cditop_reset)
        $past(hps_in.buff_wr, 2) |-> nv_core.restore_write
            && nv_core.adr == $past(restore_base, 2) + 13'd1
            && nv_core.restore_data == $past(hps_in.buff_dout[15:8], 2))
        else report_mismatch("Restore high byte wrong");
    a_rest_only: assert property (@(posedge clk_sys) disable iff (cditop_reset)
        nv_core.restore_write |-> $past(hps_in.buff_wr) || $past(hps_in.buff_wr, 2))
        else report_mismatch("Unexpected restore write");
    a_ack_blocks: assert property (@(posedge clk_sys) disable iff (cditop_reset)
        hps_in.ack |-> !nv_core.allow_cpu_access)
        else report_mismatch("CPU access allowed during a transfer");
    a_backup_go: assert property (@(posedge clk_sys) disable iff (cditop_reset)
        $rose(osd_status) && backup_pending && !hps_in.media_change && !hps_in.ack
            && nv_core.allow_cpu_access |=> hps_out.wr && !backup_pending)
        else report_mismatch("OSD open did not start the backup");
    a_din: assert property (@(posedge clk_sys) disable iff (cditop_reset)
        hps_in.buff_addr_lsb != $past(hps_in.buff_addr_lsb) |-> hps_out.din == expect_din)
        else report_mismatch("Backup word wrong at buff_addr_lsb toggle");

    initial begin
        #(WATCHDOG_NS);
        abort_run("Watchdog timeout, the test sequence did not finish");
    end

    // ========================================
    // Stimulus
    // ========================================

    initial begin
        logic [31:0] rnd;
        logic [63:0] wide;
        logic [12:0] byte_adr;
        cditop_reset      = 1'b1;
        dl                = '0;
        core_req          = '0;
        sdram_busy        = 1'b0;
        hps_in            = '0;
        nv_backup_data    = 8'h00;
        nv_cpu_changed    = 1'b0;
        osd_status        = 1'b0;
        reset_on_mount_en = 1'b0;
        busy_left         = 2'd0;
        restore_base      = '0;
        expect_din        = '0;

        repeat (RESET_CYCLES) @(posedge clk_sys);
        assert (!hps_out.rd && !hps_out.wr && !nv_core.restore_write && !worm.wr
                && !backup_pending && !dl_overflow && nv_core.allow_cpu_access)
            else report_mismatch("Outputs not idle after reset");
        cditop_reset <= 1'b0;

        // Main ROM download, spaced well apart
        dl.active <= 1'b1;
        repeat (4) @(posedge clk_sys);
        for (int i = 0; i < ROM_WRITES; i++) begin
            rnd = next_random();
            dl.addr <= rnd[24:0];
            rnd = next_random();
            dl.data <= rnd[15:0];
            dl.wr   <= 1'b1;
            @(posedge clk_sys);
            dl.wr <= 1'b0;
            repeat (ROM_SPACING - 1) @(posedge clk_sys);
        end
        assert (rom_writes_seen == ROM_WRITES && rom_expect.size() == 0)
            else report_mismatch("ROM write count differs from download words");

        // Slave WORM words
        for (int i = 0; i < WORM_WRITES; i++) begin
            rnd = next_random();
            dl.slave_sel <= 1'b1;
            dl.addr      <= {12'h000, rnd[12:1], 1'b0};
            dl.data      <= rnd[31:16];
            dl.wr        <= 1'b1;
            @(posedge clk_sys);
            dl.wr <= 1'b0;
            repeat (5) @(posedge clk_sys);
        end
        dl.slave_sel <= 1'b0;
        dl.active    <= 1'b0;
        repeat (3) @(posedge clk_sys);

        // Core requests pass straight through
        for (int i = 0; i < CORE_CYCLES; i++) begin
            wide = {next_random(), next_random()};
            core_req <= wide[$bits(sdram_req_t)-1:0];
            @(posedge clk_sys);
        end
        core_req <= '0;

        // Image mount and restore
        reset_on_mount_en   <= 1'b1;
        hps_in.img_nonzero  <= 1'b1;
        hps_in.media_change <= 1'b1;
        @(posedge clk_sys);
        hps_in.media_change <= 1'b0;
        wait_request(1'b0);
        hps_in.ack <= 1'b1;
        for (int k = 0; k < NV_WORDS; k++) begin
            repeat (2) @(posedge clk_sys);
            rnd = next_random();
            hps_in.buff_dout <= rnd[15:0];
            hps_in.buff_wr   <= 1'b1;
            restore_base     <= 13'(2 * k);
            @(posedge clk_sys);
            hps_in.buff_wr <= 1'b0;
            repeat (3) @(posedge clk_sys);
        end
        hps_in.ack <= 1'b0;
        repeat (3) @(posedge clk_sys);
        assert (nv_core.allow_cpu_access)
            else report_mismatch("CPU access not restored after the restore");

        // Change inside the early-boot window is ignored
        reset_on_mount_en <= 1'b0;
        dl.active <= 1'b1;
        @(posedge clk_sys);
        dl.active <= 1'b0;
        repeat (2) @(posedge clk_sys);
        nv_cpu_changed <= 1'b1;
        @(posedge clk_sys);
        nv_cpu_changed <= 1'b0;
        repeat (3) @(posedge clk_sys);
        assert (!backup_pending)
            else report_mismatch("Change inside the ignore window set backup_pending");
        repeat (8) @(posedge clk_sys);
        nv_cpu_changed <= 1'b1;
        @(posedge clk_sys);
        nv_cpu_changed <= 1'b0;
        @(posedge clk_sys);
        assert (backup_pending)
            else report_mismatch("Change after the ignore window left backup_pending low");

        // OSD open runs the backup
        osd_status <= 1'b1;
        wait_request(1'b1);
        hps_in.ack <= 1'b1;
        repeat (6) @(posedge clk_sys);
        for (int k = 0; k < NV_WORDS; k++) begin
            byte_adr = 13'(2 * k);
            hps_in.buff_addr_lsb <= !hps_in.buff_addr_lsb;
            expect_din <= {nv_byte(byte_adr + 13'd1), nv_byte(byte_adr)};
            repeat (6) @(posedge clk_sys);
        end
        hps_in.ack <= 1'b0;
        osd_status <= 1'b0;
        repeat (4) @(posedge clk_sys);
        assert (nv_core.allow_cpu_access && !hps_out.wr)
            else report_mismatch("Sequencer not idle after the backup");

        $display("=== PASS ===");
        $finish;
    end

endmodule
